// ==== run.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="$build_dir/sim.log"

mkdir -p "$build_dir"
if [ $? -ne 0 ]; then
    echo "Cannot create $build_dir"
    exit 1
fi

verilator --binary --timing --assert --top-module icache_tb \
    -Mdir "$build_dir/obj_dir" -o icache_sim -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"$build_dir/obj_dir/icache_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx 'All tests passed!' "$log_file"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== source/icache_addr_pkg.sv ====
package icache_addr_pkg;

    // Geometry of the 64-bit fetch address.
    localparam int tag_w      = 54;
    localparam int index_w    = 6;
    localparam int offset_w   = 4;
    localparam int word_sel_w = 2;
    localparam int num_sets   = 64;

    // The core and the next level see one flat address.
    // The lookup splits the same word into its fields.
    typedef union packed
    {
        logic [63:0] flat;
        struct packed
        {
            logic [tag_w-1:0]               tag;
            logic [index_w-1:0]             index;
            logic [word_sel_w-1:0]          word_sel;
            logic [offset_w-word_sel_w-1:0] byte_sel;
        } fields;
    } fetch_addr_t;

endpackage

// ==== source/icache_controller.sv ====
`timescale 1ns/1ns

module icache_controller
(
    input  logic                                 clk,
    input  logic                                 nrst,
    input  logic                                 fetch_valid,
    input  icache_addr_pkg::fetch_addr_t         fetch_addr,
    input  logic                                 flush,
    output logic                                 instr_valid,
    output icache_line_pkg::instr_t              instr,
    output logic                                 stall,
    output logic                                 l2_req,
    output icache_addr_pkg::fetch_addr_t         l2_addr,
    input  logic                                 l2_ready,
    input  icache_line_pkg::line_t               l2_line,
    output icache_addr_pkg::fetch_addr_t         lookup_addr,
    input  logic                                 hit,
    output logic                                 rd_en,
    output icache_addr_pkg::fetch_addr_t         rd_addr,
    input  icache_line_pkg::instr_t              rd_word,
    output logic                                 fill,
    output logic [icache_addr_pkg::index_w-1:0]  fill_index,
    output icache_line_pkg::tag_t                fill_tag
);

    localparam logic [1:0] S_IDLE        = 2'd0;
    localparam logic [1:0] S_RESPOND     = 2'd1;
    localparam logic [1:0] S_MISS_WAIT   = 2'd2;
    localparam logic [1:0] S_REFILL_RESP = 2'd3;

    logic [1:0]                   state;
    logic                         hit_q;
    logic                         pend_valid;
    icache_addr_pkg::fetch_addr_t req_addr;
    icache_addr_pkg::fetch_addr_t pend_addr;
    icache_line_pkg::instr_t      refill_word;

    logic                         new_lookup;
    logic                         park;
    logic                         replay;

    // A fetch that lands while a miss is still being decided is parked
    // and looked up again once the refill is done.
    assign park   = fetch_valid && (state == S_RESPOND) && !hit_q;
    assign replay = (state == S_REFILL_RESP) && pend_valid;

    assign new_lookup = replay ||
                        (fetch_valid && (state == S_IDLE)) ||
                        (fetch_valid && (state == S_RESPOND) && hit_q);

    assign lookup_addr = replay ? pend_addr : fetch_addr;
    assign rd_en       = new_lookup;
    assign rd_addr     = lookup_addr;

    // Core stall and next-level request span the whole miss.
    assign stall  = (state == S_MISS_WAIT) || (state == S_REFILL_RESP);
    assign l2_req = stall;
    assign l2_addr = {req_addr.fields.tag, req_addr.fields.index,
                      {icache_addr_pkg::offset_w{1'b0}}};

    assign fill       = (state == S_MISS_WAIT) && l2_ready;
    assign fill_index = req_addr.fields.index;
    assign fill_tag   = req_addr.fields.tag;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state       <= S_IDLE;
            hit_q       <= 1'b0;
            pend_valid  <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            instr_valid <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (new_lookup)
                        state <= S_RESPOND;
                end
                S_RESPOND:
                begin
                    instr_valid <= hit_q;
                    if (!hit_q)
                        state <= S_MISS_WAIT;
                    else if (!new_lookup)
                        state <= S_IDLE;
                end
                S_MISS_WAIT:
                begin
                    if (l2_ready)
                        state <= S_REFILL_RESP;
                end
                default:
                begin
                    instr_valid <= 1'b1;
                    state       <= replay ? S_RESPOND : S_IDLE;
                end
            endcase

            if (new_lookup)
                hit_q <= hit;

            if (park)
                pend_valid <= 1'b1;
            else if (replay)
                pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (new_lookup)
            req_addr <= lookup_addr;
        if (park)
            pend_addr <= fetch_addr;
        // Requested word kept from the line as it arrives.
        if (fill)
            refill_word <= l2_line[req_addr.fields.word_sel];
        if ((state == S_RESPOND) && hit_q)
            instr <= rd_word;
        else if (state == S_REFILL_RESP)
            instr <= refill_word;
    end

    assert property (@(posedge clk) disable iff (!nrst) stall |-> !fetch_valid)
        else $error("icache_controller: fetch while stalled");

    assert property (@(posedge clk) disable iff (!nrst) l2_ready |-> l2_req)
        else $error("icache_controller: l2_ready without l2_req");

    assert property (@(posedge clk) disable iff (!nrst) stall |-> !flush)
        else $error("icache_controller: flush while stalled");

endmodule

// ==== source/icache_data_array.sv ====
`timescale 1ns/1ns

module icache_data_array
(
    input  logic                                 clk,
    input  logic                                 rd_en,
    input  icache_addr_pkg::fetch_addr_t         rd_addr,
    output icache_line_pkg::instr_t              rd_word,
    input  logic                                 fill,
    input  logic [icache_addr_pkg::index_w-1:0]  fill_index,
    input  icache_line_pkg::line_t               fill_line
);

    icache_line_pkg::line_t lines [icache_addr_pkg::num_sets];

    // Whole line written on refill.
    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            lines[fill_index] <= fill_line;
        end
    end

    // Registered read of one word.
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_word <= lines[rd_addr.fields.index][rd_addr.fields.word_sel];
        end
    end

endmodule

// ==== source/icache_line_pkg.sv ====
package icache_line_pkg;

    // One instruction word.
    typedef logic [31:0] instr_t;

    // Four words per line, word 0 at the lowest address.
    typedef instr_t [3:0] line_t;

    // Tag kept per set.
    typedef logic [icache_addr_pkg::tag_w-1:0] tag_t;

endpackage

// ==== source/icache_tag_array.sv ====
`timescale 1ns/1ns

module icache_tag_array
(
    input  logic                                 clk,
    input  logic                                 nrst,
    input  icache_addr_pkg::fetch_addr_t         lookup_addr,
    output logic                                 hit,
    input  logic                                 fill,
    input  logic [icache_addr_pkg::index_w-1:0]  fill_index,
    input  icache_line_pkg::tag_t                fill_tag,
    input  logic                                 flush
);

    logic [icache_addr_pkg::num_sets-1:0] valid;
    icache_line_pkg::tag_t                tags [icache_addr_pkg::num_sets];

    logic [icache_addr_pkg::index_w-1:0]  lookup_index;
    icache_line_pkg::tag_t                lookup_tag;

    assign lookup_index = lookup_addr.fields.index;
    assign lookup_tag   = lookup_addr.fields.tag;

    // Hit needs a live entry and a matching tag.
    assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

    // Flush drops every line at once.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
        end
        else if (flush)
        begin
            valid <= '0;
        end
        else if (fill)
        begin
            valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            tags[fill_index] <= fill_tag;
        end
    end

    // Refill happens under stall and flush only without it.
    assert property (@(posedge clk) disable iff (!nrst) !(fill && flush))
        else $error("icache_tag_array: fill and flush in the same cycle");

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/1ns

module icache_top
(
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          fetch_valid,
    input  icache_addr_pkg::fetch_addr_t  fetch_addr,
    output logic                          instr_valid,
    output icache_line_pkg::instr_t       instr,
    output logic                          stall,
    input  logic                          flush,
    output logic                          l2_req,
    output icache_addr_pkg::fetch_addr_t  l2_addr,
    input  logic                          l2_ready,
    input  icache_line_pkg::line_t        l2_line
);

    icache_addr_pkg::fetch_addr_t         lookup_addr;
    logic                                 hit;
    logic                                 rd_en;
    icache_addr_pkg::fetch_addr_t         rd_addr;
    icache_line_pkg::instr_t              rd_word;
    logic                                 fill;
    logic [icache_addr_pkg::index_w-1:0]  fill_index;
    icache_line_pkg::tag_t                fill_tag;

    icache_controller i_icache_controller
    (
        .clk         (clk),
        .nrst        (nrst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .flush       (flush),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .l2_req      (l2_req),
        .l2_addr     (l2_addr),
        .l2_ready    (l2_ready),
        .l2_line     (l2_line),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_word     (rd_word),
        .fill        (fill),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag)
    );

    icache_tag_array i_icache_tag_array
    (
        .clk         (clk),
        .nrst        (nrst),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .fill        (fill),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag),
        .flush       (flush)
    );

    // Refill data comes straight from the next level.
    icache_data_array i_icache_data_array
    (
        .clk         (clk),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_word     (rd_word),
        .fill        (fill),
        .fill_index  (fill_index),
        .fill_line   (l2_line)
    );

endmodule

// ==== src.f ====
+incdir+verification
source/icache_addr_pkg.sv
source/icache_line_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_controller.sv
source/icache_top.sv
verification/icache_tb.sv

// ==== verification/icache_tests.svh ====
task automatic test_after_reset();
    logic missed;
    @(negedge clk);
    check_level(instr_valid, 1'b0, "instr_valid after reset");
    check_level(stall, 1'b0, "stall after reset");
    check_level(l2_req, 1'b0, "l2_req after reset");
    fetch_one(make_addr(54'h1, 6'd1, 2'd1), missed);
    check_miss(missed, 1'b1, "first fetch after reset");
endtask

task automatic test_miss_then_hits();
    logic missed;
    fetch_one(make_addr(54'h2a5, 6'd5, 2'd2), missed);
    check_miss(missed, 1'b1, "cold fetch");
    for (int w = 0; w < 4; w++)
    begin
        if (w != 2)
        begin
            fetch_one(make_addr(54'h2a5, 6'd5, 2'(w)), missed);
            check_miss(missed, 1'b0, "other word of a filled line");
        end
    end
endtask

// Same index, different tags.
task automatic test_conflict();
    icache_addr_pkg::fetch_addr_t a;
    icache_addr_pkg::fetch_addr_t b;
    logic                         missed;
    a = make_addr(54'h11, 6'd9, 2'd0);
    b = make_addr(54'h22, 6'd9, 2'd3);
    fetch_one(a, missed);
    check_miss(missed, 1'b1, "first line of the set");
    fetch_one(a, missed);
    check_miss(missed, 1'b0, "repeat of the first line");
    repeat (2)
    begin
        fetch_one(b, missed);
        check_miss(missed, 1'b1, "conflicting line");
        fetch_one(a, missed);
        check_miss(missed, 1'b1, "return to the evicted line");
    end
endtask

task automatic test_flush();
    icache_addr_pkg::fetch_addr_t a;
    icache_addr_pkg::fetch_addr_t b;
    logic                         missed;
    a = make_addr(54'h30, 6'd12, 2'd1);
    b = make_addr(54'h31, 6'd13, 2'd2);
    fetch_one(a, missed);
    fetch_one(b, missed);
    fetch_one(a, missed);
    check_miss(missed, 1'b0, "line before flush");
    fetch_one(b, missed);
    check_miss(missed, 1'b0, "line before flush");
    pulse_flush();
    fetch_one(a, missed);
    check_miss(missed, 1'b1, "first fetch after flush");
    fetch_one(b, missed);
    check_miss(missed, 1'b1, "first fetch after flush");
    fetch_one(a, missed);
    check_miss(missed, 1'b0, "refetch after flush");
    fetch_one(b, missed);
    check_miss(missed, 1'b0, "refetch after flush");
endtask

// Four tags over four sets keep both hits and misses frequent.
task automatic test_random_fetches();
    icache_addr_pkg::fetch_addr_t addr;
    logic                         missed;
    for (int n = 0; n < 600; n++)
    begin
        addr = make_addr(54'h3a000 + 54'($urandom_range(3)),
                         6'(16 * $urandom_range(3) + 2),
                         2'($urandom_range(3)));
        addr.fields.byte_sel = 2'($urandom_range(3));
        fetch_one(addr, missed);
    end
endtask

task automatic test_back_to_back();
    icache_addr_pkg::fetch_addr_t addrs [4];
    logic                         missed;
    for (int k = 0; k < 4; k++)
        addrs[k] = make_addr(54'h42, 6'd20, 2'(k));
    fetch_one(addrs[0], missed);
    // Fetch c is sampled one edge after it is driven and answered one edge later.
    for (int c = 0; c < 7; c++)
    begin
        @(posedge clk);
        if (c < 4)
        begin
            fetch_valid <= 1'b1;
            fetch_addr  <= addrs[c];
        end
        else
            fetch_valid <= 1'b0;
        @(negedge clk);
        check_level(stall, 1'b0, "stall during back-to-back hits");
        check_level(l2_req, 1'b0, "l2_req during back-to-back hits");
        check_level(instr_valid, (c >= 2) && (c <= 5), "instr_valid in a hit burst");
        if ((c >= 2) && (c <= 5))
            check_instr(instr, expected_instr(addrs[c-2]), "word of a hit burst");
    end
endtask

// ==== verification/icache_tb.sv ====
`timescale 1ns/1ns

module icache_tb;

    // About 700 fetches of up to 8 cycles each, plus reset.
    localparam int max_cycles = 6000;

    logic                         clk;
    logic                         nrst;
    logic                         fetch_valid;
    icache_addr_pkg::fetch_addr_t fetch_addr;
    logic                         instr_valid;
    icache_line_pkg::instr_t      instr;
    logic                         stall;
    logic                         flush;
    logic                         l2_req;
    icache_addr_pkg::fetch_addr_t l2_addr;
    logic                         l2_ready;
    icache_line_pkg::line_t       l2_line;

    logic [1:0]                   l2_wait;
    logic                         l2_served;
    int                           cycle_count;

    // Reference copy of the valid bits and tags.
    logic                         model_valid [icache_addr_pkg::num_sets];
    icache_line_pkg::tag_t        model_tag   [icache_addr_pkg::num_sets];

    icache_top i_icache_top
    (
        .clk         (clk),
        .nrst        (nrst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .flush       (flush),
        .l2_req      (l2_req),
        .l2_addr     (l2_addr),
        .l2_ready    (l2_ready),
        .l2_line     (l2_line)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Each word of a line holds the low 32 bits of its own byte address.
    function automatic icache_line_pkg::line_t line_at(input icache_addr_pkg::fetch_addr_t addr);
        icache_line_pkg::line_t line;
        for (int k = 0; k < 4; k++)
            line[k] = (addr.flat[31:0] & 32'hffff_fff0) + 32'(4 * k);
        return line;
    endfunction

    function automatic icache_line_pkg::instr_t expected_instr(
        input icache_addr_pkg::fetch_addr_t addr);
        return addr.flat[31:0] & 32'hffff_fffc;
    endfunction

    function automatic icache_addr_pkg::fetch_addr_t make_addr(
        input icache_line_pkg::tag_t                    tag,
        input logic [icache_addr_pkg::index_w-1:0]      index,
        input logic [icache_addr_pkg::word_sel_w-1:0]   word);
        icache_addr_pkg::fetch_addr_t addr;
        addr.flat            = '0;
        addr.fields.tag      = tag;
        addr.fields.index    = index;
        addr.fields.word_sel = word;
        return addr;
    endfunction

    function automatic void clear_model();
        for (int s = 0; s < icache_addr_pkg::num_sets; s++)
            model_valid[s] = 1'b0;
    endfunction

    function automatic void install_model(input icache_addr_pkg::fetch_addr_t addr);
        model_valid[addr.fields.index] = 1'b1;
        model_tag[addr.fields.index]   = addr.fields.tag;
    endfunction

    function automatic logic predict_hit(input icache_addr_pkg::fetch_addr_t addr);
        return model_valid[addr.fields.index] &&
               (model_tag[addr.fields.index] == addr.fields.tag);
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_instr(input icache_line_pkg::instr_t got,
                               input icache_line_pkg::instr_t exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_miss(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("[FAIL] %0t: %s is miss=%b, expected miss=%b",
                                      $time, what, got, exp));
    endtask

    task automatic check_addr(input icache_addr_pkg::fetch_addr_t got,
                              input icache_addr_pkg::fetch_addr_t exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // One fetch, checked against the model for outcome, address and word.
    task automatic fetch_one(input icache_addr_pkg::fetch_addr_t addr, output logic missed);
        icache_addr_pkg::fetch_addr_t line_addr;
        logic                         exp_miss;
        int                           waited;
        line_addr.flat = {addr.flat[63:4], 4'h0};
        exp_miss       = !predict_hit(addr);
        missed         = 1'b0;
        waited         = 0;
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        @(posedge clk);
        fetch_valid <= 1'b0;
        @(negedge clk);
        while (!instr_valid)
        begin
            // A miss raises both levels from the cycle after the lookup.
            check_level(stall, exp_miss && (waited > 0), "stall during the fetch");
            check_level(l2_req, exp_miss && (waited > 0), "l2_req during the fetch");
            if (l2_req && !missed)
                check_addr(l2_addr, line_addr, "l2_addr of the miss");
            missed = missed | l2_req;
            waited++;
            @(negedge clk);
        end
        check_level(stall, 1'b0, "stall with instr_valid");
        check_miss(missed, exp_miss, "outcome of the fetch");
        check_instr(instr, expected_instr(addr), "fetched instruction");
        if (!exp_miss)
            check_level(waited == 1, 1'b1, "hit delivered one cycle after the fetch");
        install_model(addr);
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        clear_model();
    endtask

    // Next level answers 3 cycles after the request rises.
    initial
    begin
        l2_ready  = 1'b0;
        l2_line   = '0;
        l2_wait   = 2'd0;
        l2_served = 1'b0;
        forever
        begin
            @(posedge clk);
            if (!l2_req)
            begin
                l2_wait   <= 2'd0;
                l2_served <= 1'b0;
            end
            else if (l2_ready)
                l2_ready <= 1'b0;
            else if (!l2_served)
            begin
                if (l2_wait == 2'd2)
                begin
                    l2_ready  <= 1'b1;
                    l2_served <= 1'b1;
                    l2_line   <= line_at(l2_addr);
                end
                else
                    l2_wait <= l2_wait + 2'd1;
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < max_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        stop_with_error($sformatf("Timeout after %0d cycles, the cache stopped answering",
                                  max_cycles));
    end

    `include "icache_tests.svh"

    initial
    begin
        nrst        = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        flush       = 1'b0;
        void'($urandom(44));
        clear_model();
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
        test_after_reset();
        test_miss_then_hits();
        test_conflict();
        test_flush();
        test_random_fetches();
        test_back_to_back();
        $display("All tests passed!");
        $finish;
    end

endmodule
